// ==== Makefile ====
SRCS := $(wildcard logic/*.sv) dv/tiny16_tb.sv dv/tiny16_model.svh

.PHONY: all run clean

all: run

obj_dir/Vtiny16_tb: all.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f all.f --top-module tiny16_tb \
		-Mdir obj_dir -o Vtiny16_tb

sim.log: obj_dir/Vtiny16_tb
	./obj_dir/Vtiny16_tb > sim.log 2>&1 || true

run: obj_dir/Vtiny16_tb
	./obj_dir/Vtiny16_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
logic/tiny16_pkg.sv
logic/tiny16_ifs.sv
logic/tiny16_control.sv
logic/tiny16_decode.sv
logic/tiny16_execute.sv
logic/tiny16_result.sv
logic/tiny16.sv
+incdir+dv
dv/tiny16_tb.sv

// ==== dv/tiny16_model.svh ====
`ifndef TINY16_MODEL_SVH
`define TINY16_MODEL_SVH

// group 5 operations the generator picks from, halt excluded
function automatic tiny16_pkg::grp5_e grp5_code(input int idx);
    case (idx)
        0: return tiny16_pkg::g5_shr;
        1: return tiny16_pkg::g5_shl;
        2: return tiny16_pkg::g5_movrr;
        3: return tiny16_pkg::g5_add;
        4: return tiny16_pkg::g5_sub;
        5: return tiny16_pkg::g5_and;
        6: return tiny16_pkg::g5_or;
        7: return tiny16_pkg::g5_xor;
        8: return tiny16_pkg::g5_test;
        9: return tiny16_pkg::g5_cmp;
        default: return tiny16_pkg::g5_swab;
    endcase
endfunction

// program at 0, stores to 80..df, ldpc target table at e0..ff
task automatic build_image();
    logic [31:0] r;
    logic [15:0] off;
    logic [12:0] v13;
    logic [10:0] v11;
    logic [8:0]  hi;
    logic [1:0]  ds;
    logic [1:0]  ss;
    int          slot;
    int          room;
    int          kind;
    slot = 0;
    for (int i = 0; i < 65536; i++) begin
        mem[i] = 16'(i) ^ {8'(i), 8'(i >> 8)} ^ 16'ha5c3;
    end
    for (int i = 'h80; i < 'he0; i++) begin
        mem[i] = 16'(lcg_next() >> 16);
    end
    for (int a = 0; a < prog_len; a++) begin
        r = lcg_next();
        kind = int'(r[31:28]) % 10;
        ds = r[27:26];
        ss = r[25:24];
        hi = r[23:15];
        room = prog_len - a;
        // forward only, never past the halt
        off = 16'(1 + int'(r[14:13]));
        if (int'(off) > room) begin
            off = 16'(room);
        end
        case (kind)
            0: begin
                v13 = 13'(off);
                mem[a] = {v13[8:0], tiny16_pkg::op_jmp, v13[12:9]};
            end
            1: mem[a] = {off[8:0], tiny16_pkg::op_br, r[3], r[2:0]};
            2: begin
                v11 = r[23:13];
                mem[a] = {v11[8:0], tiny16_pkg::op_mvl, ds, v11[10:9]};
            end
            3: begin
                hi = 9'(128 + int'(r[12:6]) % 96);
                mem[a] = {hi, tiny16_pkg::op_st, 2'd0, ss};
            end
            4: mem[a] = {hi, tiny16_pkg::op_ld, ds, ss};
            5: begin
                if (slot < 32) begin
                    mem[224 + slot] = 16'(a) + off;
                    mem[a] = {9'(224 + slot), tiny16_pkg::op_ldpc, 2'd0, 2'd0};
                    slot++;
                end else begin
                    mem[a] = {hi, tiny16_pkg::op_ld, ds, ss};
                end
            end
            default: mem[a] = {grp5_code(int'(r[12:9]) % 11), tiny16_pkg::op_grp5, ds, ss};
        endcase
    end
    mem[prog_len] = {tiny16_pkg::g5_halt, tiny16_pkg::op_grp5, 4'd0};
    model_mem = mem;
endtask

// instruction-level run to halt, fills the expected bus sequence
task automatic model_run();
    logic [15:0] r [4];
    logic [15:0] pc;
    logic [15:0] cur;
    logic [15:0] ins;
    logic [15:0] acc;
    logic [15:0] d;
    logic [15:0] s;
    logic [15:0] addr;
    logic [15:0] imm9;
    logic [16:0] wide;
    logic [8:0]  hi;
    logic [1:0]  ds;
    logic [1:0]  ss;
    logic        c;
    logic        z;
    logic        n;
    logic        done;
    int          steps;
    pc = reset_pc;
    acc = 16'h0000;
    c = 1'b0;
    done = 1'b0;
    steps = 0;
    for (int i = 0; i < 4; i++) begin
        r[i] = 16'h0000;
    end
    while (!done && steps < 2000) begin
        cur = pc;
        ins = model_mem[cur];
        hi = ins[15:7];
        ds = ins[3:2];
        ss = ins[1:0];
        imm9 = {{7{hi[8]}}, hi};
        d = r[ds];
        s = r[ss];
        z = (acc == 16'h0000);
        n = acc[15];
        expect_access(1'b0, cur, 16'h0000);
        steps++;
        pc = cur + 16'd1;
        case (ins[6:4])
            tiny16_pkg::op_jmp: pc = cur + {{3{ins[3]}}, ins[3:0], hi};
            tiny16_pkg::op_br: begin
                // mask over c, z, n with optional inversion
                if ((|(ins[2:0] & {c, z, n})) ^ ins[3]) begin
                    pc = cur + imm9;
                end
            end
            tiny16_pkg::op_mvl: r[ds] = {{5{ins[1]}}, ins[1:0], hi};
            tiny16_pkg::op_st: begin
                addr = ((ds == 2'd0) ? 16'h0000 : d) + imm9;
                expect_access(1'b1, addr, s);
                model_mem[addr] = s;
            end
            tiny16_pkg::op_ld: begin
                addr = ((ss == 2'd0) ? 16'h0000 : s) + imm9;
                expect_access(1'b0, addr, 16'h0000);
                r[ds] = model_mem[addr];
            end
            tiny16_pkg::op_ldpc: begin
                addr = ((ss == 2'd0) ? 16'h0000 : s) + imm9;
                expect_access(1'b0, addr, 16'h0000);
                pc = model_mem[addr];
            end
            tiny16_pkg::op_grp5: begin
                case (hi)
                    tiny16_pkg::g5_halt: done = 1'b1;
                    tiny16_pkg::g5_shr: begin
                        c = d[0];
                        acc = d >> 1;
                        r[ds] = acc;
                    end
                    tiny16_pkg::g5_shl: begin
                        c = d[15];
                        acc = d << 1;
                        r[ds] = acc;
                    end
                    tiny16_pkg::g5_movrr: r[ds] = s;
                    tiny16_pkg::g5_add: begin
                        wide = {1'b0, d} + {1'b0, s};
                        {c, acc} = wide;
                        r[ds] = acc;
                    end
                    tiny16_pkg::g5_sub,
                    tiny16_pkg::g5_cmp: begin
                        // carry holds the borrow
                        wide = {1'b0, d} - {1'b0, s};
                        {c, acc} = wide;
                        if (hi == tiny16_pkg::g5_sub) begin
                            r[ds] = acc;
                        end
                    end
                    tiny16_pkg::g5_and,
                    tiny16_pkg::g5_test: begin
                        acc = d & s;
                        if (hi == tiny16_pkg::g5_and) begin
                            r[ds] = acc;
                        end
                    end
                    tiny16_pkg::g5_or: begin
                        acc = d | s;
                        r[ds] = acc;
                    end
                    tiny16_pkg::g5_xor: begin
                        acc = d ^ s;
                        r[ds] = acc;
                    end
                    tiny16_pkg::g5_swab: r[ds] = {s[7:0], s[15:8]};
                    default: ;
                endcase
            end
            default: ;
        endcase
    end
endtask

`endif

// ==== dv/tiny16_tb.sv ====
`timescale 1ns/1ps

module tiny16_tb;

    localparam logic [15:0] reset_pc = 16'h0000;
    localparam int prog_len = 120;
    // worst case per instruction well under 12 cycles
    localparam int watchdog_ns = (prog_len + 1) * 12 * 8 + 1000;

    logic        clk;
    logic        nreset;
    logic [15:0] mem_addr;
    logic [15:0] mem_wdata;
    logic [15:0] mem_rdata;
    logic        mem_rd;
    logic        mem_wr;
    logic        mem_ready;
    logic        halted;

    logic [31:0] seed;
    logic [15:0] mem [65536];
    logic [15:0] model_mem [65536];
    logic        exp_kind [$];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    int          errors;
    int          accesses;
    int          wait_left;
    logic        busy;
    logic [15:0] held_addr;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic expect_access(input logic is_wr, input logic [15:0] addr,
                                 input logic [15:0] data);
        exp_kind.push_back(is_wr);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    `include "tiny16_model.svh"

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    // one access finishes at the coming rising edge
    task automatic complete_access();
        logic        is_wr;
        logic [15:0] addr;
        logic [15:0] data;
        if (exp_kind.size() == 0) begin
            errors++;
            $display("bus access at %0t ns after the expected sequence had ended", $time);
            return;
        end
        is_wr = exp_kind.pop_front();
        addr = exp_addr.pop_front();
        data = exp_data.pop_front();
        check_value($sformatf("access %0d is a write", accesses), 32'(is_wr), 32'(mem_wr));
        check_value($sformatf("access %0d address", accesses), 32'(addr), 32'(mem_addr));
        if (is_wr) begin
            check_value($sformatf("access %0d write data", accesses), 32'(data),
                        32'(mem_wdata));
        end
        if (mem_wr) begin
            mem[mem_addr] = mem_wdata;
        end
        accesses++;
    endtask

    tiny16 #(
        .reset_pc (reset_pc)
    ) dut_i (
        .clk       (clk),
        .nreset    (nreset),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_ready (mem_ready),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // monitor, outputs are settled by the falling edge
    always @(negedge clk) begin
        if (nreset) begin
            check_value("both strobes high", 32'd0, 32'(mem_rd && mem_wr));
            if (halted && (mem_rd || mem_wr)) begin
                errors++;
                $display("bus strobe seen at %0t ns while the core is halted", $time);
            end
            if ((mem_rd || mem_wr) && mem_ready) begin
                complete_access();
                busy = 1'b0;
            end
        end
    end

    // memory responder with 0 to 3 wait cycles
    always @(posedge clk) begin
        #1;
        if (!nreset) begin
            mem_ready = 1'b0;
        end else if (mem_rd || mem_wr) begin
            if (!busy) begin
                busy = 1'b1;
                wait_left = int'(lcg_next() >> 30);
                held_addr = mem_addr;
            end else begin
                check_value("address held while waiting", 32'(held_addr), 32'(mem_addr));
            end
            if (wait_left == 0) begin
                mem_ready = 1'b1;
                mem_rdata = mem[mem_addr];
            end else begin
                mem_ready = 1'b0;
                wait_left--;
            end
        end else begin
            mem_ready = 1'b0;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired: the core never halted, %0d errors so far", errors);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        nreset = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = 16'h0000;
        busy = 1'b0;
        wait_left = 0;
        held_addr = 16'h0000;
        errors = 0;
        accesses = 0;
        seed = 32'h4714_f5ca;
        build_image();
        model_run();
        repeat (2) @(posedge clk);
        #1;
        check_value("mem_rd in reset", 32'd0, 32'(mem_rd));
        check_value("mem_wr in reset", 32'd0, 32'(mem_wr));
        check_value("halted in reset", 32'd0, 32'(halted));
        nreset = 1'b1;
        wait (halted === 1'b1);
        // quiet bus after halt
        repeat (20) @(posedge clk);
        check_value("expected accesses never seen", 32'd0, 32'(exp_kind.size()));
        $display("run complete: %0d bus accesses, %0d errors", accesses, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/tiny16.sv ====
`timescale 1ns/1ps

module tiny16 #(
    parameter logic [15:0] reset_pc = 16'h0000
) (
    input  logic        clk,
    input  logic        nreset,
    output logic [15:0] mem_addr,
    output logic [15:0] mem_wdata,
    input  logic [15:0] mem_rdata,
    output logic        mem_rd,
    output logic        mem_wr,
    input  logic        mem_ready,
    output logic        halted
);

    logic [15:0] instr;

    dec_if  dec ();
    exec_if exec ();
    reg_if  regs ();

    tiny16_control u_control (
        .clk       (clk),
        .nreset    (nreset),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_ready (mem_ready),
        .halted    (halted),
        .instr     (instr),
        .exec      (exec.control)
    );

    tiny16_decode u_decode (
        .instr (instr),
        .dec   (dec.source)
    );

    tiny16_execute #(
        .reset_pc (reset_pc)
    ) u_execute (
        .clk    (clk),
        .nreset (nreset),
        .dec    (dec.sink),
        .exec   (exec.execute),
        .regs   (regs.execute)
    );

    tiny16_result u_result (
        .clk    (clk),
        .nreset (nreset),
        .dec    (dec.sink),
        .regs   (regs.regfile)
    );

endmodule

// ==== logic/tiny16_control.sv ====
`timescale 1ns/1ps

module tiny16_control (
    input  logic        clk,
    input  logic        nreset,
    output logic [15:0] mem_addr,
    output logic [15:0] mem_wdata,
    input  logic [15:0] mem_rdata,
    output logic        mem_rd,
    output logic        mem_wr,
    input  logic        mem_ready,
    output logic        halted,
    output logic [15:0] instr,
    exec_if.control     exec
);

    tiny16_pkg::seq_state_e state;
    logic [15:0]            rd_data;
    logic                   need_mem;

    assign need_mem = exec.need_read | exec.need_write;

    // sequencer
    always_ff @(posedge clk) begin
        if (!nreset) begin
            // parked in write-back with a nop, so the first fetch follows release
            state <= tiny16_pkg::st_wb;
            instr <= tiny16_pkg::nop_word;
        end else begin
            case (state)
                tiny16_pkg::st_fetch: begin
                    if (mem_ready) begin
                        instr <= mem_rdata;
                        state <= tiny16_pkg::st_exec;
                    end
                end
                tiny16_pkg::st_exec: begin
                    if (exec.halt_req) begin
                        state <= tiny16_pkg::st_halt;
                    end else if (need_mem) begin
                        state <= tiny16_pkg::st_mem;
                    end else begin
                        state <= tiny16_pkg::st_wb;
                    end
                end
                tiny16_pkg::st_mem: begin
                    if (mem_ready) begin
                        state <= tiny16_pkg::st_wb;
                    end
                end
                tiny16_pkg::st_wb: begin
                    state <= tiny16_pkg::st_fetch;
                end
                default: begin
                    // st_halt, left only by reset
                    state <= tiny16_pkg::st_halt;
                end
            endcase
        end
    end

    // load data, captured when the data read completes
    always_ff @(posedge clk) begin
        if (state == tiny16_pkg::st_mem && exec.need_read && mem_ready) begin
            rd_data <= mem_rdata;
        end
    end

    assign exec.load_data = rd_data;
    assign exec.exec_en   = (state == tiny16_pkg::st_exec);
    assign exec.mem_done  = (state == tiny16_pkg::st_wb);

    // bus strobes held for the whole state, address stable until ready
    assign mem_rd = (state == tiny16_pkg::st_fetch) ||
                    (state == tiny16_pkg::st_mem && exec.need_read);
    assign mem_wr = (state == tiny16_pkg::st_mem) && exec.need_write;
    assign mem_addr  = (state == tiny16_pkg::st_mem) ? exec.data_addr : exec.pc;
    assign mem_wdata = exec.data_wdata;

    assign halted = (state == tiny16_pkg::st_halt);

endmodule

// ==== logic/tiny16_decode.sv ====
`timescale 1ns/1ps

module tiny16_decode (
    input  logic [15:0] instr,
    dec_if.source       dec
);

    logic [8:0]  hi9;
    logic [10:0] val11;
    logic [12:0] val13;

    // upper nine bits carry the group 5 code or the low immediate bits
    assign hi9 = instr[tiny16_pkg::hi_hi:tiny16_pkg::hi_lo];

    assign dec.op = tiny16_pkg::op_e'(instr[tiny16_pkg::op_hi:tiny16_pkg::op_lo]);

    // anything outside the known set runs as a nop
    always_comb begin
        case (hi9)
            tiny16_pkg::g5_halt,
            tiny16_pkg::g5_shr,
            tiny16_pkg::g5_shl,
            tiny16_pkg::g5_movrr,
            tiny16_pkg::g5_add,
            tiny16_pkg::g5_sub,
            tiny16_pkg::g5_and,
            tiny16_pkg::g5_or,
            tiny16_pkg::g5_xor,
            tiny16_pkg::g5_test,
            tiny16_pkg::g5_cmp,
            tiny16_pkg::g5_swab: begin
                dec.grp5 = tiny16_pkg::grp5_e'(hi9);
            end
            default: begin
                dec.grp5 = tiny16_pkg::g5_nop;
            end
        endcase
    end

    // register selects
    assign dec.dest_sel = instr[tiny16_pkg::dst_hi:tiny16_pkg::dst_lo];
    assign dec.src_sel  = instr[tiny16_pkg::src_hi:tiny16_pkg::src_lo];

    // branch condition, mask over {c, z, n}
    assign dec.cond     = instr[2:0];
    assign dec.cond_neg = instr[tiny16_pkg::neg_bit];

    // split immediates, high part sits in the low nibble
    assign val11 = {instr[tiny16_pkg::src_hi:tiny16_pkg::src_lo], hi9};
    assign val13 = {instr[tiny16_pkg::dst_hi:tiny16_pkg::src_lo], hi9};

    assign dec.imm9  = {{7{hi9[8]}}, hi9};
    assign dec.imm11 = {{5{val11[10]}}, val11};
    assign dec.imm13 = {{3{val13[12]}}, val13};

endmodule

// ==== logic/tiny16_execute.sv ====
`timescale 1ns/1ps

module tiny16_execute #(
    parameter logic [15:0] reset_pc = 16'h0000
) (
    input  logic     clk,
    input  logic     nreset,
    dec_if.sink      dec,
    exec_if.execute  exec,
    reg_if.execute   regs
);

    logic [15:0] pc;
    logic [15:0] acc;
    logic        c;
    logic        z;
    logic        n;
    logic [2:0]  cond_hit;
    logic        br_taken;
    logic        is_grp5;
    logic        writes_reg;
    logic [15:0] ld_base;
    logic [15:0] st_base;
    logic [15:0] data_addr;
    logic [15:0] data_wdata;

    assign is_grp5 = (dec.op == tiny16_pkg::op_grp5);

    // flags
    assign z = (acc == 16'h0000);
    assign n = acc[15];

    assign cond_hit = dec.cond & {c, z, n};
    assign br_taken = (|cond_hit) ^ dec.cond_neg;

    // register 0 as a base reads as zero
    assign ld_base = (dec.src_sel == 2'd0) ? 16'h0000 : regs.src_data;
    assign st_base = (dec.dest_sel == 2'd0) ? 16'h0000 : regs.dst_data;

    // pc, acc and carry
    always_ff @(posedge clk) begin
        if (!nreset) begin
            pc  <= reset_pc;
            acc <= 16'h0000;
            c   <= 1'b0;
        end else if (exec.exec_en) begin
            case (dec.op)
                tiny16_pkg::op_jmp:  pc <= pc + dec.imm13;
                tiny16_pkg::op_br:   pc <= br_taken ? pc + dec.imm9 : pc + 16'd1;
                default:             pc <= pc + 16'd1;
            endcase
            if (is_grp5) begin
                case (dec.grp5)
                    tiny16_pkg::g5_add: {c, acc} <= {1'b0, regs.dst_data} + {1'b0, regs.src_data};
                    tiny16_pkg::g5_sub,
                    tiny16_pkg::g5_cmp: {c, acc} <= {1'b0, regs.dst_data} - {1'b0, regs.src_data};
                    tiny16_pkg::g5_shl: {c, acc} <= {regs.dst_data, 1'b0};
                    tiny16_pkg::g5_shr: {acc, c} <= {1'b0, regs.dst_data};
                    tiny16_pkg::g5_and,
                    tiny16_pkg::g5_test: acc <= regs.dst_data & regs.src_data;
                    tiny16_pkg::g5_or:  acc <= regs.dst_data | regs.src_data;
                    tiny16_pkg::g5_xor: acc <= regs.dst_data ^ regs.src_data;
                    default: ;
                endcase
            end
        end else if (exec.mem_done && dec.op == tiny16_pkg::op_ldpc) begin
            pc <= exec.load_data;
        end
    end

    // data address and store data
    always_ff @(posedge clk) begin
        if (exec.exec_en) begin
            data_addr  <= (dec.op == tiny16_pkg::op_st) ? st_base + dec.imm9
                                                          : ld_base + dec.imm9;
            data_wdata <= regs.src_data;
        end
    end

    assign exec.pc         = pc;
    assign exec.data_addr  = data_addr;
    assign exec.data_wdata = data_wdata;
    assign exec.need_read  = (dec.op == tiny16_pkg::op_ld) || (dec.op == tiny16_pkg::op_ldpc);
    assign exec.need_write = (dec.op == tiny16_pkg::op_st);
    assign exec.halt_req   = exec.exec_en && is_grp5 && (dec.grp5 == tiny16_pkg::g5_halt);

    // test and cmp only set flags
    always_comb begin
        case (dec.op)
            tiny16_pkg::op_mvl,
            tiny16_pkg::op_ld:   writes_reg = 1'b1;
            tiny16_pkg::op_grp5: writes_reg = !(dec.grp5 inside {tiny16_pkg::g5_halt,
                                                                 tiny16_pkg::g5_test,
                                                                 tiny16_pkg::g5_cmp,
                                                                 tiny16_pkg::g5_nop});
            default:             writes_reg = 1'b0;
        endcase
    end

    assign regs.wb_en     = exec.mem_done && writes_reg;
    assign regs.acc       = acc;
    assign regs.load_data = exec.load_data;

endmodule

// ==== logic/tiny16_ifs.sv ====
`timescale 1ns/1ps

// decoded instruction fields
interface dec_if;
    tiny16_pkg::op_e   op;
    tiny16_pkg::grp5_e grp5;
    logic [1:0]        dest_sel;
    logic [1:0]        src_sel;
    logic [2:0]        cond;
    logic              cond_neg;
    logic [15:0]       imm9;
    logic [15:0]       imm11;
    logic [15:0]       imm13;

    modport source (
        output op, grp5, dest_sel, src_sel, cond, cond_neg, imm9, imm11, imm13
    );

    modport sink (
        input op, grp5, dest_sel, src_sel, cond, cond_neg, imm9, imm11, imm13
    );
endinterface

// sequencer to execute handshake
interface exec_if;
    logic        exec_en;
    logic        mem_done;
    logic [15:0] load_data;
    logic [15:0] pc;
    logic [15:0] data_addr;
    logic [15:0] data_wdata;
    logic        need_read;
    logic        need_write;
    logic        halt_req;

    modport control (
        output exec_en, mem_done, load_data,
        input  pc, data_addr, data_wdata, need_read, need_write, halt_req
    );

    modport execute (
        input  exec_en, mem_done, load_data,
        output pc, data_addr, data_wdata, need_read, need_write, halt_req
    );
endinterface

// register file read ports and write-back
interface reg_if;
    logic [15:0] src_data;
    logic [15:0] dst_data;
    logic        wb_en;
    logic [15:0] acc;
    logic [15:0] load_data;

    modport execute (
        input  src_data, dst_data,
        output wb_en, acc, load_data
    );

    modport regfile (
        input  wb_en, acc, load_data,
        output src_data, dst_data
    );
endinterface

// ==== logic/tiny16_pkg.sv ====
package tiny16_pkg;

    // major opcode, instruction bits 6:4
    typedef enum logic [2:0] {
        op_jmp  = 3'd0,
        op_br   = 3'd1,
        op_mvl  = 3'd2,
        op_st   = 3'd3,
        op_ld   = 3'd4,
        op_grp5 = 3'd5,
        op_ldpc = 3'd6,
        op_call = 3'd7
    } op_e;

    // group 5 operation, instruction bits 15:7
    typedef enum logic [8:0] {
        g5_halt  = 9'h000,
        g5_shr   = 9'h003,
        g5_shl   = 9'h004,
        g5_movrr = 9'h005,
        g5_add   = 9'h006,
        g5_sub   = 9'h007,
        g5_and   = 9'h008,
        g5_or    = 9'h009,
        g5_xor   = 9'h00a,
        g5_test  = 9'h00b,
        g5_cmp   = 9'h00c,
        g5_swab  = 9'h010,
        g5_nop   = 9'h1fe
    } grp5_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_exec,
        st_mem,
        st_wb,
        st_halt
    } seq_state_e;

    // group 5 with code 1fe, decodes as g5_nop
    localparam logic [15:0] nop_word = 16'hff50;

    // instruction field positions
    localparam int op_lo  = 4;
    localparam int op_hi  = 6;
    localparam int hi_lo  = 7;
    localparam int hi_hi  = 15;
    localparam int dst_lo = 2;
    localparam int dst_hi = 3;
    localparam int src_lo = 0;
    localparam int src_hi = 1;
    localparam int neg_bit = 3;

endpackage

// ==== logic/tiny16_result.sv ====
`timescale 1ns/1ps

module tiny16_result (
    input  logic    clk,
    input  logic    nreset,
    dec_if.sink     dec,
    reg_if.regfile  regs
);

    // A, W, X, SP
    logic [15:0] rf [4];
    logic [15:0] src_val;
    logic [15:0] wb_data;

    assign src_val = rf[dec.src_sel];

    assign regs.src_data = src_val;
    assign regs.dst_data = rf[dec.dest_sel];

    // write-back source
    always_comb begin
        case (dec.op)
            tiny16_pkg::op_mvl: wb_data = dec.imm11;
            tiny16_pkg::op_ld:  wb_data = regs.load_data;
            default: begin
                case (dec.grp5)
                    tiny16_pkg::g5_movrr: wb_data = src_val;
                    tiny16_pkg::g5_swab:  wb_data = {src_val[7:0], src_val[15:8]};
                    default:              wb_data = regs.acc;
                endcase
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            for (int i = 0; i < 4; i++) begin
                rf[i] <= 16'h0000;
            end
        end else if (regs.wb_en) begin
            rf[dec.dest_sel] <= wb_data;
        end
    end

endmodule
